// File: sources.f
+incdir+bench
verilog/regex_pkg.sv
verilog/memory_arbiter.sv
verilog/match_thread.sv
verilog/regex_controller.sv
verilog/regex_top.sv
bench/regex_tb.sv

// File: Bender.yml
package:
  name: regex_coprocessor

sources:
  - files:
      - verilog/regex_pkg.sv
      - verilog/memory_arbiter.sv
      - verilog/match_thread.sv
      - verilog/regex_controller.sv
      - verilog/regex_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/regex_tb.sv

// File: bench/regex_cases.svh
`ifndef REGEX_CASES_SVH
`define REGEX_CASES_SVH

// one job per row, the rows run back to back
// prog: words 0..7, opcode in [15:14] (0 match, 1 any, 2 jmp, 3 accept), operand in [7:0]
// text: characters stored from character address 32 upward
// then start_ptr, end_ptr, expected accept, expected read of the word holding end_ptr
typedef struct packed {
    regex_pkg::instr_t [0:7]    prog;
    logic [0:7][7:0]            text;
    logic [31:0]                start_ptr;
    logic [31:0]                end_ptr;
    logic                       exp_accept;
    logic                       exp_end_read;
} job_case_t;

localparam int NUM_CASES = 8;

localparam job_case_t CASES [NUM_CASES] = '{
    // match a, match b, accept on the terminator
    '{'{16'h0061, 16'h0062, 16'hc000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "ab$-----", 32'd32, 32'd34, 1'b1, 1'b1},
    // b fails at 33, terminator word never fetched
    '{'{16'h0061, 16'h0062, 16'hc000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "ax$-----", 32'd32, 32'd34, 1'b0, 1'b0},
    // same job right after a reject
    '{'{16'h0061, 16'h0062, 16'hc000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "ab$-----", 32'd32, 32'd34, 1'b1, 1'b1},
    // any, jmp 0 never accepts and runs out at the terminator
    '{'{16'h4000, 16'h8000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "abcde$--", 32'd32, 32'd37, 1'b0, 1'b1},
    // odd start, jmp skips match z, accept at 36 before word 19
    '{'{16'h0063, 16'h8003, 16'h007a, 16'h4000, 16'h0065, 16'hc000, 16'h0, 16'h0},
      "xcdefgh$", 32'd33, 32'd39, 1'b1, 1'b0},
    // same program, match e fails on q at 35
    '{'{16'h0063, 16'h8003, 16'h007a, 16'h4000, 16'h0065, 16'hc000, 16'h0, 16'h0},
      "xcdqfgh$", 32'd33, 32'd39, 1'b0, 1'b0},
    // empty string, accept on the terminator itself
    '{'{16'hc000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "$-------", 32'd32, 32'd32, 1'b1, 1'b1},
    // match of the terminator parks the thread, so accept is never fetched
    '{'{16'h0061, 16'h0024, 16'hc000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
      "a$------", 32'd32, 32'd33, 1'b0, 1'b1}
};

`endif

// File: bench/regex_tb.sv
`timescale 1ns/1ps

module regex_tb;

    `include "regex_cases.svh"

    localparam int TEXT_BASE      = 32;
    localparam int PROG_WORDS     = 8;
    localparam int MEM_WORDS      = 2 ** regex_pkg::ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = NUM_CASES * 200;

    logic                            clk;
    logic                            rst;
    logic                            valid;
    logic                            ready;
    logic [31:0]                     start_ptr;
    logic [31:0]                     end_ptr;
    logic                            done;
    logic                            accept;
    regex_pkg::mem_req_t             mem_req;
    logic                            mem_ready;
    logic [regex_pkg::MEM_WIDTH-1:0] mem_data;

    // memory model contents by word address
    logic [regex_pkg::MEM_WIDTH-1:0] mem [MEM_WORDS];
    logic [31:0]                     lfsr;
    // set once the word holding end_ptr has been read in the current job
    logic                            end_word_read;
    int                              checks;
    int                              value_errors;
    int                              other_errors;
    int                              done_count;
    int                              cycle_count;

    regex_top regex_top_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .ready      (ready),
        .start_ptr  (start_ptr),
        .end_ptr    (end_ptr),
        .done       (done),
        .accept     (accept),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_data   (mem_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form stepped once per bit handed out
    function automatic logic next_lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
        begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    // stall only when both drawn bits are zero
    function automatic logic draw_mem_ready();
        logic b0;
        logic b1;
        b0 = next_lfsr_bit();
        b1 = next_lfsr_bit();
        return b0 | b1;
    endfunction

    // filler tags the word and carries its full address
    function automatic logic [regex_pkg::MEM_WIDTH-1:0] fill_word(input int addr);
        return {5'b10110, addr[10:0]};
    endfunction

    task automatic load_memory(input job_case_t job);
        int a;
        int caddr;
        for (a = 0; a < MEM_WORDS; a++)
        begin
            mem[a] = fill_word(a);
        end
        for (a = 0; a < PROG_WORDS; a++)
        begin
            mem[a] = job.prog[a];
        end
        // even character in the low byte of its word
        for (a = 0; a < 8; a++)
        begin
            caddr = TEXT_BASE + a;
            mem[caddr / regex_pkg::CHARS_PER_WORD]
                [regex_pkg::CHAR_WIDTH * (caddr % regex_pkg::CHARS_PER_WORD) +: 8] = job.text[a];
        end
    endtask

    task automatic check_accept(input string name, input logic got, input logic exp,
                                input int row);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("FAIL %s row %0d got %h expected %h", name, row, got, exp);
        end
    endtask

    // legal reads are the program words and the words of the current string
    task automatic check_req_addr(input regex_pkg::mem_req_t req);
        logic [regex_pkg::ADDR_WIDTH-1:0] lo;
        logic [regex_pkg::ADDR_WIDTH-1:0] hi;
        lo = regex_pkg::ADDR_WIDTH'(start_ptr / regex_pkg::CHARS_PER_WORD);
        hi = regex_pkg::ADDR_WIDTH'(end_ptr / regex_pkg::CHARS_PER_WORD);
        checks++;
        if (!(req.addr < PROG_WORDS || (req.addr >= lo && req.addr <= hi)))
        begin
            value_errors++;
            $display("FAIL mem_req.addr got %h expected below %h or in %h..%h",
                     req.addr, PROG_WORDS, lo, hi);
        end
    endtask

    // memory answers one cycle after acceptance
    always @(posedge clk)
    begin
        if (mem_req.valid && mem_ready)
        begin
            check_req_addr(mem_req);
            mem_data <= mem[mem_req.addr];
            if (mem_req.addr == regex_pkg::ADDR_WIDTH'(end_ptr / regex_pkg::CHARS_PER_WORD))
            begin
                end_word_read = 1'b1;
            end
        end
        mem_ready <= draw_mem_ready();
    end

    always @(posedge clk)
    begin
        if (!rst && done)
        begin
            done_count++;
        end
    end

    task automatic run_job(input job_case_t job, input int row);
        logic accepted;
        logic done_seen;
        accepted      = 1'b0;
        done_seen     = 1'b0;
        load_memory(job);
        end_word_read = 1'b0;
        valid     <= 1'b1;
        start_ptr <= job.start_ptr;
        end_ptr   <= job.end_ptr;
        while (!done_seen)
        begin
            @(posedge clk);
            if (done)
            begin
                done_seen = 1'b1;
                if (!accepted)
                begin
                    other_errors++;
                    $display("done raised before job %0d was accepted", row);
                end
                check_accept("accept", accept, job.exp_accept, row);
                check_accept("end word read", end_word_read, job.exp_end_read, row);
            end
            // an idle controller is the only requester, so it is granted whenever memory is ready
            if (valid)
            begin
                check_accept("ready", ready, mem_ready, row);
            end
            if (valid && ready)
            begin
                accepted = 1'b1;
                valid   <= 1'b0;
            end
        end
    endtask

    initial
    begin
        int row;
        clk           = 1'b0;
        rst           = 1'b1;
        valid         = 1'b0;
        start_ptr     = '0;
        end_ptr       = '0;
        mem_ready     = 1'b1;
        mem_data      = '0;
        lfsr          = 32'h0b95ba58;
        end_word_read = 1'b0;
        checks        = 0;
        value_errors  = 0;
        other_errors  = 0;
        done_count    = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // quiet port until a job is offered
        repeat (4)
        begin
            @(posedge clk);
            check_accept("done", done, 1'b0, -1);
            check_accept("accept", accept, 1'b0, -1);
            check_accept("ready", ready, 1'b0, -1);
            check_accept("mem_req.valid", mem_req.valid, 1'b0, -1);
        end
        for (row = 0; row < NUM_CASES; row++)
        begin
            run_job(CASES[row], row);
        end
        repeat (4)
        begin
            @(posedge clk);
            check_accept("done", done, 1'b0, NUM_CASES);
        end
        if (done_count != NUM_CASES)
        begin
            other_errors++;
            $display("saw %0d done strobes for %0d jobs", done_count, NUM_CASES);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors + 1);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog/regex_top.sv
`timescale 1ns/1ps

module regex_top #(
    parameter int PTR_WIDTH = 32,
    parameter int PC_WIDTH  = 8
)
(
    input  logic                            clk,
    input  logic                            rst,
    // job port
    input  logic                            valid,
    output logic                            ready,
    input  logic [PTR_WIDTH-1:0]            start_ptr,
    input  logic [PTR_WIDTH-1:0]            end_ptr,
    output logic                            done,
    output logic                            accept,
    // shared memory port
    output regex_pkg::mem_req_t             mem_req,
    input  logic                            mem_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0] mem_data
);

    // controller side of the memory arbiter
    regex_pkg::mem_req_t            char_req;
    regex_pkg::mem_rsp_t            char_rsp;
    logic                           char_gnt;
    // matching unit side of the memory arbiter
    regex_pkg::mem_req_t            instr_req;
    regex_pkg::mem_rsp_t            instr_rsp;
    logic                           instr_gnt;
    // controller to matching unit
    regex_pkg::thread_status_t      thread_status;
    logic                           thread_start;
    logic                           thread_flush;
    logic                           exec_en;
    logic [regex_pkg::CHAR_WIDTH-1:0] cur_char;
    logic                           cur_parity;

    regex_controller #(
        .PTR_WIDTH      (PTR_WIDTH)
    ) controller_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .ready          (ready),
        .start_ptr      (start_ptr),
        .end_ptr        (end_ptr),
        .done           (done),
        .accept         (accept),
        .char_req       (char_req),
        .char_gnt       (char_gnt),
        .char_rsp       (char_rsp),
        .thread_status  (thread_status),
        .thread_start   (thread_start),
        .thread_flush   (thread_flush),
        .exec_en        (exec_en),
        .cur_char       (cur_char),
        .cur_parity     (cur_parity)
    );

    match_thread #(
        .PC_WIDTH       (PC_WIDTH)
    ) thread_i (
        .clk            (clk),
        .rst            (rst),
        .thread_start   (thread_start),
        .thread_flush   (thread_flush),
        .exec_en        (exec_en),
        .cur_char       (cur_char),
        .cur_parity     (cur_parity),
        .instr_req      (instr_req),
        .instr_gnt      (instr_gnt),
        .instr_rsp      (instr_rsp),
        .thread_status  (thread_status)
    );

    memory_arbiter arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .char_req       (char_req),
        .instr_req      (instr_req),
        .char_gnt       (char_gnt),
        .instr_gnt      (instr_gnt),
        .char_rsp       (char_rsp),
        .instr_rsp      (instr_rsp),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data)
    );

endmodule

// File: verilog/regex_controller.sv
`timescale 1ns/1ps

module regex_controller #(
    parameter int PTR_WIDTH = 32
)
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    output logic                              ready,
    input  logic [PTR_WIDTH-1:0]              start_ptr,
    input  logic [PTR_WIDTH-1:0]              end_ptr,
    output logic                              done,
    output logic                              accept,
    output regex_pkg::mem_req_t               char_req,
    input  logic                              char_gnt,
    input  regex_pkg::mem_rsp_t               char_rsp,
    input  regex_pkg::thread_status_t         thread_status,
    output logic                              thread_start,
    output logic                              thread_flush,
    output logic                              exec_en,
    output logic [regex_pkg::CHAR_WIDTH-1:0]  cur_char,
    output logic                              cur_parity
);

    regex_pkg::ctrl_state_e     state, state_next;
    logic [PTR_WIDTH-1:0]       ptr, ptr_next;
    logic [PTR_WIDTH-1:0]       ptr_inc;
    logic                       parity_next;
    // buffered memory word, one slot per character
    logic [regex_pkg::CHARS_PER_WORD-1:0][regex_pkg::CHAR_WIDTH-1:0] word_buf, word_next;
    logic                       word_cross;

    assign ptr_inc    = ptr + PTR_WIDTH'(1);
    // next character lives in the following word
    assign word_cross = (ptr_inc[regex_pkg::CHAR_SEL_WIDTH-1:0] == '0);
    // low pointer bits pick the character out of the buffered word
    assign cur_char   = word_buf[ptr[regex_pkg::CHAR_SEL_WIDTH-1:0]];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= regex_pkg::IDLE;
            ptr        <= '0;
            cur_parity <= 1'b1;
        end
        else
        begin
            state      <= state_next;
            ptr        <= ptr_next;
            cur_parity <= parity_next;
        end
    end

    always_ff @(posedge clk)
    begin
        word_buf <= word_next;
    end

    always_comb
    begin
        state_next     = state;
        ptr_next       = ptr;
        parity_next    = cur_parity;
        word_next      = word_buf;
        ready          = 1'b0;
        done           = 1'b0;
        accept         = 1'b0;
        char_req       = '0;
        thread_start   = 1'b0;
        thread_flush   = 1'b0;
        exec_en        = 1'b0;
        unique case (state)
            regex_pkg::IDLE:
            begin
                // ask for the first word as soon as a job is offered
                char_req.valid = valid;
                char_req.addr  = start_ptr[regex_pkg::CHAR_SEL_WIDTH +: regex_pkg::ADDR_WIDTH];
                ready          = char_gnt;
                if (valid && char_gnt)
                begin
                    state_next  = regex_pkg::FETCH_FIRST;
                    ptr_next    = start_ptr;
                    parity_next = 1'b1;
                end
            end
            regex_pkg::FETCH_FIRST:
            begin
                // word arrives now, thread starts at pc 0 on the same cycle
                if (char_rsp.valid)
                begin
                    word_next = char_rsp.data;
                end
                thread_start = 1'b1;
                state_next   = regex_pkg::EXEC;
            end
            regex_pkg::EXEC:
            begin
                exec_en = 1'b1;
                if (thread_status.accept)
                begin
                    state_next = regex_pkg::DONE_ACCEPT;
                end
                else if (!thread_status.busy && !thread_status.alive)
                begin
                    // thread died on a failed match
                    state_next = regex_pkg::DONE_REJECT;
                end
                else if (!thread_status.busy && ptr == end_ptr)
                begin
                    // terminator consumed without accept
                    state_next = regex_pkg::DONE_REJECT;
                end
                else if (!thread_status.busy && word_cross)
                begin
                    // step only once the next word is on its way
                    char_req.valid = 1'b1;
                    char_req.addr  = ptr_inc[regex_pkg::CHAR_SEL_WIDTH +: regex_pkg::ADDR_WIDTH];
                    if (char_gnt)
                    begin
                        state_next  = regex_pkg::FETCH_NEXT;
                        ptr_next    = ptr_inc;
                        parity_next = ~cur_parity;
                    end
                end
                else if (!thread_status.busy)
                begin
                    // next character already sits in the buffer
                    state_next  = regex_pkg::NO_FETCH_NEXT;
                    ptr_next    = ptr_inc;
                    parity_next = ~cur_parity;
                end
            end
            regex_pkg::FETCH_NEXT:
            begin
                if (char_rsp.valid)
                begin
                    word_next = char_rsp.data;
                end
                state_next = thread_status.alive ? regex_pkg::EXEC : regex_pkg::DONE_REJECT;
            end
            regex_pkg::NO_FETCH_NEXT:
            begin
                // buffer unchanged so the thread may keep going
                exec_en    = 1'b1;
                state_next = thread_status.alive ? regex_pkg::EXEC : regex_pkg::DONE_REJECT;
            end
            regex_pkg::DONE_ACCEPT:
            begin
                done         = 1'b1;
                accept       = 1'b1;
                thread_flush = 1'b1;
                state_next   = regex_pkg::IDLE;
            end
            regex_pkg::DONE_REJECT:
            begin
                done         = 1'b1;
                thread_flush = 1'b1;
                state_next   = regex_pkg::IDLE;
            end
            default:
            begin
                state_next = regex_pkg::IDLE;
            end
        endcase
    end

    // accept is only reported for a thread that actually reached ACCEPT
    accept_with_done_a: assert property (@(posedge clk) disable iff (rst)
        accept |-> done && thread_status.accept);

    // no word fetch while finishing, and the flush has killed the thread a cycle later
    done_flush_a: assert property (@(posedge clk) disable iff (rst)
        done |-> !char_req.valid ##1 !thread_status.alive);

endmodule

// File: verilog/match_thread.sv
`timescale 1ns/1ps

module match_thread #(
    parameter int PC_WIDTH = 8
)
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              thread_start,
    input  logic                              thread_flush,
    input  logic                              exec_en,
    input  logic [regex_pkg::CHAR_WIDTH-1:0]  cur_char,
    input  logic                              cur_parity,
    output regex_pkg::mem_req_t               instr_req,
    input  logic                              instr_gnt,
    input  regex_pkg::mem_rsp_t               instr_rsp,
    output regex_pkg::thread_status_t         thread_status
);

    logic [PC_WIDTH-1:0]    pc;
    logic                   alive;
    // character parity this thread is waiting for
    logic                   tag;
    // request accepted, instruction due next cycle
    logic                   pending;
    logic                   accept_q;
    logic                   busy;
    regex_pkg::instr_t      instr;

    assign instr = regex_pkg::instr_t'(instr_rsp.data);

    // work left for the current character
    assign busy = alive && !accept_q && (tag == cur_parity);

    // fetch at pc, nothing new while one is in flight
    assign instr_req.valid = exec_en && busy && !pending;
    assign instr_req.addr  = regex_pkg::ADDR_WIDTH'(pc);

    assign thread_status.accept = accept_q;
    assign thread_status.busy   = busy;
    assign thread_status.alive  = alive;

    always_ff @(posedge clk)
    begin
        if (rst || thread_flush)
        begin
            // end of job also kills the thread
            pc       <= '0;
            alive    <= 1'b0;
            tag      <= 1'b1;
            pending  <= 1'b0;
            accept_q <= 1'b0;
        end
        else if (thread_start)
        begin
            pc       <= '0;
            alive    <= 1'b1;
            tag      <= cur_parity;
            pending  <= 1'b0;
            accept_q <= 1'b0;
        end
        else
        begin
            if (instr_gnt)
            begin
                pending <= 1'b1;
            end
            // instruction executes in the cycle it comes back
            if (instr_rsp.valid)
            begin
                pending <= 1'b0;
                unique case (instr.opcode)
                    regex_pkg::OP_MATCH:
                    begin
                        if (instr.operand == cur_char)
                        begin
                            // park until the controller moves on
                            pc  <= pc + PC_WIDTH'(1);
                            tag <= ~tag;
                        end
                        else
                        begin
                            alive <= 1'b0;
                        end
                    end
                    regex_pkg::OP_ANY:
                    begin
                        pc  <= pc + PC_WIDTH'(1);
                        tag <= ~tag;
                    end
                    regex_pkg::OP_JMP:
                    begin
                        // refetch next cycle on the same character
                        pc <= instr.operand[PC_WIDTH-1:0];
                    end
                    regex_pkg::OP_ACCEPT:
                    begin
                        accept_q <= 1'b1;
                    end
                    default:
                    begin
                        alive <= 1'b0;
                    end
                endcase
            end
        end
    end

    // controller must flush before handing out a new job
    start_when_dead_a: assert property (@(posedge clk) disable iff (rst)
        thread_start |-> !alive);

    // arbiter only returns data for a fetch this thread had accepted
    rsp_after_gnt_a: assert property (@(posedge clk) disable iff (rst)
        instr_rsp.valid |-> pending && $past(instr_gnt));

endmodule

// File: verilog/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  regex_pkg::mem_req_t              char_req,
    input  regex_pkg::mem_req_t              instr_req,
    output logic                             char_gnt,
    output logic                             instr_gnt,
    output regex_pkg::mem_rsp_t              char_rsp,
    output regex_pkg::mem_rsp_t              instr_rsp,
    output regex_pkg::mem_req_t              mem_req,
    input  logic                             mem_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0]  mem_data
);

    // a read was accepted last cycle
    logic rsp_due;
    // high when that read belongs to the controller
    logic owner_char;

    // character fetches win over instruction fetches
    assign mem_req   = char_req.valid ? char_req : instr_req;
    assign char_gnt  = char_req.valid && mem_ready;
    assign instr_gnt = instr_req.valid && !char_req.valid && mem_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rsp_due <= 1'b0;
        end
        else
        begin
            rsp_due <= mem_req.valid && mem_ready;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_req.valid && mem_ready)
        begin
            owner_char <= char_req.valid;
        end
    end

    // data goes to both sides but valid only to the owner
    assign char_rsp.valid  = rsp_due && owner_char;
    assign char_rsp.data   = mem_data;
    assign instr_rsp.valid = rsp_due && !owner_char;
    assign instr_rsp.data  = mem_data;

    one_grant_a: assert property (@(posedge clk) disable iff (rst)
        !(char_gnt && instr_gnt));

    // a stalled request stays put until memory takes it
    req_hold_a: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_ready |=> $stable(mem_req));

endmodule

// File: verilog/regex_pkg.sv
package regex_pkg;

    // character and memory word geometry
    localparam int CHAR_WIDTH     = 8;
    localparam int MEM_WIDTH      = 16;
    localparam int CHARS_PER_WORD = 2;
    // low pointer bits that pick a character inside a word
    localparam int CHAR_SEL_WIDTH = 1;
    // memory is word addressed
    localparam int ADDR_WIDTH     = 11;

    // instruction set of the matching unit
    typedef enum logic [1:0] {
        // character must equal operand, then step to next char at pc+1
        OP_MATCH  = 2'd0,
        // any character, then step to next char at pc+1
        OP_ANY    = 2'd1,
        // pc takes operand, same character
        OP_JMP    = 2'd2,
        // match succeeds
        OP_ACCEPT = 2'd3
    } opcode_e;

    // one instruction fills exactly one memory word
    typedef struct packed {
        opcode_e                opcode;
        logic [5:0]             spare;
        // a character for MATCH, a target pc for JMP
        logic [CHAR_WIDTH-1:0]  operand;
    } instr_t;

    // supervising FSM states
    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        EXEC,
        FETCH_NEXT,
        NO_FETCH_NEXT,
        DONE_ACCEPT,
        DONE_REJECT
    } ctrl_state_e;

    // memory read request, held until accepted
    typedef struct packed {
        logic                   valid;
        logic [ADDR_WIDTH-1:0]  addr;
    } mem_req_t;

    // read data routed back to the owner of the request
    typedef struct packed {
        logic                   valid;
        logic [MEM_WIDTH-1:0]   data;
    } mem_rsp_t;

    // matching unit status seen by the controller
    typedef struct packed {
        logic accept;
        logic busy;
        logic alive;
    } thread_status_t;

endpackage
